// File: hdl/axil_mon_pkg.sv
// AXI-lite bus monitor shared definitions
// Bus widths, per-channel beat payloads and the fault vectors
// produced by the write and read trackers
package axil_mon_pkg;

	////////////////////
	// Bus widths
	////////////////////

	localparam int AXIL_ADDR_W = 28;
	localparam int AXIL_DATA_W = 32;
	localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

	// Width of the first-fault index, enough for 16 fault bits
	localparam int FAULT_IDX_W = 4;

	// OKAY, EXOKAY, SLVERR, DECERR
	typedef logic [1:0] axil_resp_t;

	////////////////////
	// Channel beats
	////////////////////

	// Address channels carry only the address
	typedef struct packed {
		logic [AXIL_ADDR_W-1:0] addr;
	} axil_aw_beat_t;

	typedef struct packed {
		logic [AXIL_ADDR_W-1:0] addr;
	} axil_ar_beat_t;

	typedef struct packed {
		logic [AXIL_DATA_W-1:0] data;
		logic [AXIL_STRB_W-1:0] strb;
	} axil_w_beat_t;

	typedef struct packed {
		logic [AXIL_DATA_W-1:0] data;
		axil_resp_t             resp;
	} axil_r_beat_t;

	typedef struct packed {
		axil_resp_t resp;
	} axil_b_beat_t;

	////////////////////
	// Fault vectors
	////////////////////

	// Write side, first field is the most significant bit
	typedef struct packed {
		logic aw_unstable;
		logic w_unstable;
		logic b_unstable;
		logic aw_stall;
		logic w_stall;
		logic b_stall;
		logic wr_timeout;
		logic b_orphan;
		logic wr_overflow;
	} axil_wr_fault_t;

	// Read side, rd_overflow ends up as bit 0 of the full vector
	typedef struct packed {
		logic ar_unstable;
		logic r_unstable;
		logic ar_stall;
		logic r_stall;
		logic rd_timeout;
		logic r_orphan;
		logic rd_overflow;
	} axil_rd_fault_t;

	// Full 16-bit vector, write part in the upper bits
	typedef struct packed {
		axil_wr_fault_t wr;
		axil_rd_fault_t rd;
	} axil_fault_t;

endpackage

// File: hdl/axil_chan_watch.sv
// Single AXI-lite channel watcher
// Produces the handshake pulse, flags a payload change or a dropped
// valid while the channel is stalled, and flags a stall that lasts
// MAX_STALL cycles unless the caller exempts it
`timescale 1ns/1ps

module axil_chan_watch #(
	parameter type payload_t = logic [7:0],
	parameter int  MAX_STALL = 12
) (
	input  logic     i_clk,
	input  logic     i_axi_reset_n,
	input  logic     i_valid,
	input  logic     i_ready,
	input  payload_t i_beat,
	input  logic     i_exempt,
	output logic     o_fire,
	output logic     o_unstable,
	output logic     o_stall_over
);

	// Counter saturates at MAX_STALL
	localparam int TMR_W = $clog2(MAX_STALL + 1);

	logic             stalled;
	logic             prev_stall;
	payload_t         prev_beat;
	logic [TMR_W-1:0] stall_cnt;
	logic             stall_count_en;

	// Channel is holding a beat the other side has not taken
	assign stalled = i_valid && !i_ready;

	// A handshake only counts outside reset
	assign o_fire = i_valid && i_ready && i_axi_reset_n;

	////////////////////
	// Stability check
	////////////////////

	// Last cycle's stall state
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			prev_stall <= 1'b0;
		else
			prev_stall <= stalled;
	end

	// Payload snapshot, compared only after a stalled cycle
	always_ff @(posedge i_clk)
	begin
		prev_beat <= i_beat;
	end

	// Once stalled, valid must stay up and the beat must not move
	assign o_unstable = prev_stall && (!i_valid || (i_beat != prev_beat));

	////////////////////
	// Stall length
	////////////////////

	assign stall_count_en = stalled && !i_exempt;

	// Consecutive unexempted stall cycles before this one
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n || !stall_count_en)
			stall_cnt <= '0;
		else if (stall_cnt != TMR_W'(MAX_STALL))
			stall_cnt <= stall_cnt + 1'b1;
	end

	// Single pulse in the cycle the run length hits the limit
	assign o_stall_over = stall_count_en && (stall_cnt == TMR_W'(MAX_STALL - 1));

endmodule

// File: hdl/axil_wr_tracker.sv
// AXI-lite write side tracker
// Watches AW, W and B, counts outstanding address and data beats,
// times the write response and flags orphaned responses and
// counter overflow, all as single-cycle fault pulses
`timescale 1ns/1ps

module axil_wr_tracker import axil_mon_pkg::*; #(
	parameter int LGDEPTH    = 4,
	parameter int MAX_WAIT   = 12,
	parameter int MAX_RSTALL = 12,
	parameter int MAX_DELAY  = 12
) (
	input  logic               i_clk,
	input  logic               i_axi_reset_n,
	input  logic               i_aw_valid,
	input  logic               i_aw_ready,
	input  axil_aw_beat_t      i_aw_beat,
	input  logic               i_w_valid,
	input  logic               i_w_ready,
	input  axil_w_beat_t       i_w_beat,
	input  logic               i_b_valid,
	input  logic               i_b_ready,
	input  axil_b_beat_t       i_b_beat,
	output logic [LGDEPTH-1:0] o_awr_outstanding,
	output logic [LGDEPTH-1:0] o_wr_outstanding,
	output axil_wr_fault_t     o_fault
);

	// Timer sized for the largest of the three limits
	localparam int MAX_LIM_A = (MAX_WAIT > MAX_RSTALL) ? MAX_WAIT : MAX_RSTALL;
	localparam int MAX_LIMIT = (MAX_LIM_A > MAX_DELAY) ? MAX_LIM_A : MAX_DELAY;
	localparam int TMR_W     = $clog2(MAX_LIMIT + 1);

	logic             aw_fire, w_fire, b_fire;
	logic             aw_unstable, w_unstable, b_unstable;
	logic             aw_stall, w_stall, b_stall;
	logic             resp_wait;
	logic [TMR_W-1:0] resp_tmr;

	////////////////////
	// Channel watches
	////////////////////

	// A pending BVALID can legitimately hold off new requests
	axil_chan_watch #(.payload_t(axil_aw_beat_t), .MAX_STALL(MAX_WAIT)) u_aw_watch (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_valid(i_aw_valid), .i_ready(i_aw_ready), .i_beat(i_aw_beat),
		.i_exempt(i_b_valid),
		.o_fire(aw_fire), .o_unstable(aw_unstable), .o_stall_over(aw_stall)
	);

	axil_chan_watch #(.payload_t(axil_w_beat_t), .MAX_STALL(MAX_WAIT)) u_w_watch (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_valid(i_w_valid), .i_ready(i_w_ready), .i_beat(i_w_beat),
		.i_exempt(i_b_valid),
		.o_fire(w_fire), .o_unstable(w_unstable), .o_stall_over(w_stall)
	);

	// Response stall is never exempt
	axil_chan_watch #(.payload_t(axil_b_beat_t), .MAX_STALL(MAX_RSTALL)) u_b_watch (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_valid(i_b_valid), .i_ready(i_b_ready), .i_beat(i_b_beat),
		.i_exempt(1'b0),
		.o_fire(b_fire), .o_unstable(b_unstable), .o_stall_over(b_stall)
	);

	////////////////////
	// Outstanding counts
	////////////////////

	// Address beats awaiting B, request and response together cancel
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			o_awr_outstanding <= '0;
		else if (aw_fire && !b_fire)
			o_awr_outstanding <= o_awr_outstanding + 1'b1;
		else if (!aw_fire && b_fire)
			o_awr_outstanding <= o_awr_outstanding - 1'b1;
	end

	// Data beats awaiting B
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			o_wr_outstanding <= '0;
		else if (w_fire && !b_fire)
			o_wr_outstanding <= o_wr_outstanding + 1'b1;
		else if (!w_fire && b_fire)
			o_wr_outstanding <= o_wr_outstanding - 1'b1;
	end

	////////////////////
	// Response timer
	////////////////////

	// Only a full write (address and data) is owed a response
	assign resp_wait = (o_awr_outstanding != '0) && (o_wr_outstanding != '0) && !i_b_valid;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n || !resp_wait)
			resp_tmr <= '0;
		else if (resp_tmr != TMR_W'(MAX_DELAY))
			resp_tmr <= resp_tmr + 1'b1;
	end

	// Fault pulses for the collector
	always_comb
	begin
		o_fault.aw_unstable = aw_unstable;
		o_fault.w_unstable  = w_unstable;
		o_fault.b_unstable  = b_unstable;
		o_fault.aw_stall    = aw_stall;
		o_fault.w_stall     = w_stall;
		o_fault.b_stall     = b_stall;
		o_fault.wr_timeout  = resp_wait && (resp_tmr == TMR_W'(MAX_DELAY - 1));
		// BVALID needs both an address and a data beat behind it
		o_fault.b_orphan    = i_b_valid &&
				((o_awr_outstanding == '0) || (o_wr_outstanding == '0));
		o_fault.wr_overflow = (&o_awr_outstanding) || (&o_wr_outstanding);
	end

endmodule

// File: hdl/axil_rd_tracker.sv
// AXI-lite read side tracker
// Watches AR and R, counts outstanding reads, times the read
// response and flags orphaned R beats and counter overflow
`timescale 1ns/1ps

module axil_rd_tracker import axil_mon_pkg::*; #(
	parameter int LGDEPTH    = 4,
	parameter int MAX_WAIT   = 12,
	parameter int MAX_RSTALL = 12,
	parameter int MAX_DELAY  = 12
) (
	input  logic               i_clk,
	input  logic               i_axi_reset_n,
	input  logic               i_ar_valid,
	input  logic               i_ar_ready,
	input  axil_ar_beat_t      i_ar_beat,
	input  logic               i_r_valid,
	input  logic               i_r_ready,
	input  axil_r_beat_t       i_r_beat,
	output logic [LGDEPTH-1:0] o_rd_outstanding,
	output axil_rd_fault_t     o_fault
);

	localparam int MAX_LIM_A = (MAX_WAIT > MAX_RSTALL) ? MAX_WAIT : MAX_RSTALL;
	localparam int MAX_LIMIT = (MAX_LIM_A > MAX_DELAY) ? MAX_LIM_A : MAX_DELAY;
	localparam int TMR_W     = $clog2(MAX_LIMIT + 1);

	logic             ar_fire, r_fire;
	logic             ar_unstable, r_unstable;
	logic             ar_stall, r_stall;
	logic             resp_wait;
	logic [TMR_W-1:0] resp_tmr;

	// AR stall is excused while an R beat is pending
	axil_chan_watch #(.payload_t(axil_ar_beat_t), .MAX_STALL(MAX_WAIT)) u_ar_watch (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_valid(i_ar_valid), .i_ready(i_ar_ready), .i_beat(i_ar_beat),
		.i_exempt(i_r_valid),
		.o_fire(ar_fire), .o_unstable(ar_unstable), .o_stall_over(ar_stall)
	);

	axil_chan_watch #(.payload_t(axil_r_beat_t), .MAX_STALL(MAX_RSTALL)) u_r_watch (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_valid(i_r_valid), .i_ready(i_r_ready), .i_beat(i_r_beat),
		.i_exempt(1'b0),
		.o_fire(r_fire), .o_unstable(r_unstable), .o_stall_over(r_stall)
	);

	// Reads accepted but not yet answered
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			o_rd_outstanding <= '0;
		else if (ar_fire && !r_fire)
			o_rd_outstanding <= o_rd_outstanding + 1'b1;
		else if (!ar_fire && r_fire)
			o_rd_outstanding <= o_rd_outstanding - 1'b1;
	end

	// Cleared whenever RVALID shows up, stalled or not
	assign resp_wait = (o_rd_outstanding != '0) && !i_r_valid;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n || !resp_wait)
			resp_tmr <= '0;
		else if (resp_tmr != TMR_W'(MAX_DELAY))
			resp_tmr <= resp_tmr + 1'b1;
	end

	always_comb
	begin
		o_fault.ar_unstable = ar_unstable;
		o_fault.r_unstable  = r_unstable;
		o_fault.ar_stall    = ar_stall;
		o_fault.r_stall     = r_stall;
		o_fault.rd_timeout  = resp_wait && (resp_tmr == TMR_W'(MAX_DELAY - 1));
		o_fault.r_orphan    = i_r_valid && (o_rd_outstanding == '0);
		o_fault.rd_overflow = &o_rd_outstanding;
	end

endmodule

// File: hdl/axil_fault_collect.sv
// Fault collector for the AXI-lite monitor
// Merges write and read fault pulses into sticky flags, records
// the index of the first fault seen and drives the summary flag
`timescale 1ns/1ps

module axil_fault_collect import axil_mon_pkg::*; (
	input  logic                   i_clk,
	input  logic                   i_axi_reset_n,
	input  axil_wr_fault_t         i_wr_fault,
	input  axil_rd_fault_t         i_rd_fault,
	output axil_fault_t            o_fault_flags,
	output logic [FAULT_IDX_W-1:0] o_first_fault,
	output logic                   o_fault
);

	axil_fault_t pulses;

	// Index of the lowest set bit, zero when none is set
	function automatic logic [FAULT_IDX_W-1:0] lowest_bit(input axil_fault_t vec);
		logic [FAULT_IDX_W-1:0] idx;
		idx = '0;
		// Walk downwards so the lowest hit wins
		for (int i = $bits(axil_fault_t) - 1; i >= 0; i--)
		begin
			if (vec[i])
				idx = FAULT_IDX_W'(i);
		end
		return idx;
	endfunction

	// Write part lands in the upper bits
	assign pulses = '{wr: i_wr_fault, rd: i_rd_fault};

	////////////////////
	// Sticky state
	////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_fault_flags <= '0;
			o_first_fault <= '0;
			o_fault       <= 1'b0;
		end
		else
		begin
			// Flags only ever rise until the next reset
			o_fault_flags <= o_fault_flags | pulses;
			// Latch once, on the first pulse into a clean vector
			if ((o_fault_flags == '0) && (pulses != '0))
				o_first_fault <= lowest_bit(pulses);
			// Summary trails the flags by one cycle
			o_fault <= |o_fault_flags;
		end
	end

endmodule

// File: hdl/axil_monitor_top.sv
// AXI-lite bus monitor top level
// Packs the flat bus ports into channel beats and connects the
// write tracker, the read tracker and the fault collector
`timescale 1ns/1ps

module axil_monitor_top import axil_mon_pkg::*; #(
	parameter int LGDEPTH    = 4,
	parameter int MAX_WAIT   = 12,
	parameter int MAX_RSTALL = 12,
	parameter int MAX_DELAY  = 12
) (
	input  logic                   i_clk,
	input  logic                   i_axi_reset_n,
	// Write address
	input  logic                   i_axi_awvalid,
	input  logic                   i_axi_awready,
	input  logic [AXIL_ADDR_W-1:0] i_axi_awaddr,
	// Write data
	input  logic                   i_axi_wvalid,
	input  logic                   i_axi_wready,
	input  logic [AXIL_DATA_W-1:0] i_axi_wdata,
	input  logic [AXIL_STRB_W-1:0] i_axi_wstrb,
	// Write response
	input  logic                   i_axi_bvalid,
	input  logic                   i_axi_bready,
	input  axil_resp_t             i_axi_bresp,
	// Read address
	input  logic                   i_axi_arvalid,
	input  logic                   i_axi_arready,
	input  logic [AXIL_ADDR_W-1:0] i_axi_araddr,
	// Read data
	input  logic                   i_axi_rvalid,
	input  logic                   i_axi_rready,
	input  logic [AXIL_DATA_W-1:0] i_axi_rdata,
	input  axil_resp_t             i_axi_rresp,
	// Status
	output logic [LGDEPTH-1:0]     o_awr_outstanding,
	output logic [LGDEPTH-1:0]     o_wr_outstanding,
	output logic [LGDEPTH-1:0]     o_rd_outstanding,
	output axil_fault_t            o_fault_flags,
	output logic [FAULT_IDX_W-1:0] o_first_fault,
	output logic                   o_fault
);

	axil_aw_beat_t  aw_beat;
	axil_w_beat_t   w_beat;
	axil_b_beat_t   b_beat;
	axil_ar_beat_t  ar_beat;
	axil_r_beat_t   r_beat;
	axil_wr_fault_t wr_fault;
	axil_rd_fault_t rd_fault;

	// Beat packing
	assign aw_beat = '{addr: i_axi_awaddr};
	assign w_beat  = '{data: i_axi_wdata, strb: i_axi_wstrb};
	assign b_beat  = '{resp: i_axi_bresp};
	assign ar_beat = '{addr: i_axi_araddr};
	assign r_beat  = '{data: i_axi_rdata, resp: i_axi_rresp};

	axil_wr_tracker #(
		.LGDEPTH(LGDEPTH), .MAX_WAIT(MAX_WAIT),
		.MAX_RSTALL(MAX_RSTALL), .MAX_DELAY(MAX_DELAY)
	) u_wr_tracker (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_aw_valid(i_axi_awvalid), .i_aw_ready(i_axi_awready), .i_aw_beat(aw_beat),
		.i_w_valid(i_axi_wvalid), .i_w_ready(i_axi_wready), .i_w_beat(w_beat),
		.i_b_valid(i_axi_bvalid), .i_b_ready(i_axi_bready), .i_b_beat(b_beat),
		.o_awr_outstanding(o_awr_outstanding),
		.o_wr_outstanding(o_wr_outstanding),
		.o_fault(wr_fault)
	);

	axil_rd_tracker #(
		.LGDEPTH(LGDEPTH), .MAX_WAIT(MAX_WAIT),
		.MAX_RSTALL(MAX_RSTALL), .MAX_DELAY(MAX_DELAY)
	) u_rd_tracker (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_ar_valid(i_axi_arvalid), .i_ar_ready(i_axi_arready), .i_ar_beat(ar_beat),
		.i_r_valid(i_axi_rvalid), .i_r_ready(i_axi_rready), .i_r_beat(r_beat),
		.o_rd_outstanding(o_rd_outstanding),
		.o_fault(rd_fault)
	);

	// Sticky flags live only here
	axil_fault_collect u_fault_collect (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_wr_fault(wr_fault), .i_rd_fault(rd_fault),
		.o_fault_flags(o_fault_flags),
		.o_first_fault(o_first_fault),
		.o_fault(o_fault)
	);

endmodule

// File: tests/tb_clk_gen.sv
// Testbench clock and reset source
// Free-running clock, a reset held for the first cycles after start
// and a reset that the testbench can request at any time
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int CLK_PERIOD = 4,
	parameter int RST_CYCLES = 2
) (
	input  logic i_rst_req,
	output logic o_clk,
	output logic o_rst_n
);

	logic init_rst;

	initial
	begin
		o_clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) o_clk = ~o_clk;
	end

	// Power-on reset, released on a falling edge
	initial
	begin
		init_rst = 1'b1;
		repeat (RST_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		init_rst = 1'b0;
	end

	// Active low, either source holds it
	assign o_rst_n = !(init_rst || i_rst_req);

endmodule

// File: tests/axil_monitor_assertions.sv
// Concurrent checks on the AXI-lite monitor fault collector
// Sticky flags never fall outside reset, the summary flag follows
// the flags one cycle later and the first-fault index holds
`timescale 1ns/1ps

module axil_monitor_assertions import axil_mon_pkg::*; (
	input logic                   i_clk,
	input logic                   i_axi_reset_n,
	input axil_fault_t            i_fault_flags,
	input logic [FAULT_IDX_W-1:0] i_first_fault,
	input logic                   i_fault
);

	// Failure tally, polled by the testbench
	int assert_errors = 0;

	// Every flag set one cycle ago is still set
	flags_sticky: assert property (@(posedge i_clk)
		$past(i_axi_reset_n) |->
			((i_fault_flags & $past(i_fault_flags)) == $past(i_fault_flags)))
	else
	begin
		$error("sticky fault flag fell while reset was inactive");
		assert_errors++;
	end

	// Summary is the registered OR of the flags
	summary_follows: assert property (@(posedge i_clk)
		$past(i_axi_reset_n) |-> (i_fault == (|$past(i_fault_flags))))
	else
	begin
		$error("summary fault flag does not match the flags of the previous cycle");
		assert_errors++;
	end

	// Index is frozen once the summary is up
	first_held: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		i_fault |-> $stable(i_first_fault))
	else
	begin
		$error("first-fault index moved while a fault was reported");
		assert_errors++;
	end

endmodule

bind axil_fault_collect axil_monitor_assertions u_fault_asserts (
	.i_clk(i_clk),
	.i_axi_reset_n(i_axi_reset_n),
	.i_fault_flags(o_fault_flags),
	.i_first_fault(o_first_fault),
	.i_fault(o_fault)
);

// File: tests/tb_axil_monitor.sv
// Testbench for the AXI-lite bus monitor
// Applies a table of bus scenarios, each after a reset, and checks
// the sticky flags, the first-fault index and the outstanding counts
`timescale 1ns/1ps

module tb_axil_monitor import axil_mon_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int LGDEPTH    = 4;
	localparam int LIMIT      = 6;
	localparam int NUM_ROWS   = 7;
	// Watchdog budget per table row
	localparam int ROW_CYCLES = 60;

	// Scenario codes
	localparam logic [3:0] SC_CLEAN      = 4'd1;
	localparam logic [3:0] SC_RD_PENDING = 4'd2;
	localparam logic [3:0] SC_W_UNSTABLE = 4'd3;
	localparam logic [3:0] SC_R_ORPHAN   = 4'd4;
	localparam logic [3:0] SC_WR_TIMEOUT = 4'd5;
	localparam logic [3:0] SC_B_STALL    = 4'd6;
	localparam logic [3:0] SC_RESET_CLR  = 4'd7;

	// Fault bit positions with the write part on top in declaration order
	localparam int FB_W_UNSTABLE = 14;
	localparam int FB_B_STALL    = 10;
	localparam int FB_WR_TIMEOUT = 9;
	localparam int FB_R_STALL    = 3;
	localparam int FB_R_ORPHAN   = 1;

	typedef struct packed {
		logic [3:0]         code;
		logic [31:0]        seed;
		logic [15:0]        exp_flags;
		logic [3:0]         exp_first;
		logic [LGDEPTH-1:0] exp_awr;
		logic [LGDEPTH-1:0] exp_wr;
		logic [LGDEPTH-1:0] exp_rd;
	} row_t;

	row_t rows [NUM_ROWS];

	logic                   clk, rst_n, rst_req;
	logic                   awvalid, awready, wvalid, wready, bvalid, bready;
	logic                   arvalid, arready, rvalid, rready;
	logic [AXIL_ADDR_W-1:0] awaddr, araddr;
	logic [AXIL_DATA_W-1:0] wdata, rdata;
	logic [AXIL_STRB_W-1:0] wstrb;
	axil_resp_t             bresp, rresp;
	logic [LGDEPTH-1:0]     awr_cnt, wr_cnt, rd_cnt;
	axil_fault_t            fault_flags;
	logic [FAULT_IDX_W-1:0] first_fault;
	logic                   fault;
	int                     row_idx;
	int                     assert_fails;

	tb_clk_gen #(.CLK_PERIOD(CLK_PERIOD), .RST_CYCLES(2)) u_clk_gen (
		.i_rst_req(rst_req), .o_clk(clk), .o_rst_n(rst_n)
	);

	axil_monitor_top #(
		.LGDEPTH(LGDEPTH), .MAX_WAIT(LIMIT), .MAX_RSTALL(LIMIT), .MAX_DELAY(LIMIT)
	) u_dut (
		.i_clk(clk), .i_axi_reset_n(rst_n),
		.i_axi_awvalid(awvalid), .i_axi_awready(awready), .i_axi_awaddr(awaddr),
		.i_axi_wvalid(wvalid), .i_axi_wready(wready),
		.i_axi_wdata(wdata), .i_axi_wstrb(wstrb),
		.i_axi_bvalid(bvalid), .i_axi_bready(bready), .i_axi_bresp(bresp),
		.i_axi_arvalid(arvalid), .i_axi_arready(arready), .i_axi_araddr(araddr),
		.i_axi_rvalid(rvalid), .i_axi_rready(rready),
		.i_axi_rdata(rdata), .i_axi_rresp(rresp),
		.o_awr_outstanding(awr_cnt), .o_wr_outstanding(wr_cnt), .o_rd_outstanding(rd_cnt),
		.o_fault_flags(fault_flags), .o_first_fault(first_fault), .o_fault(fault)
	);

	// Failures counted by the bound assertions
	assign assert_fails = u_dut.u_fault_collect.u_fault_asserts.assert_errors;

	////////////////////
	// Check and drive helpers
	////////////////////

	task automatic compare(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("Fail at %0t ns: %s = 'h%0h, expected 'h%0h (row %0d)",
				$time, name, actual, expected, row_idx);
			$display("Test failures found");
			$fatal(1, "output mismatch");
		end
	endtask

	// All handshake lines low while payloads keep their values
	task automatic bus_idle();
		awvalid = 1'b0;
		awready = 1'b0;
		wvalid  = 1'b0;
		wready  = 1'b0;
		bvalid  = 1'b0;
		bready  = 1'b0;
		arvalid = 1'b0;
		arready = 1'b0;
		rvalid  = 1'b0;
		rready  = 1'b0;
	endtask

	// Two cycles of reset entered and left on falling edges
	task automatic apply_reset();
		bus_idle();
		rst_req = 1'b1;
		repeat (2) @(negedge clk);
		rst_req = 1'b0;
	endtask

	// AW and W accepted together in one cycle
	task automatic write_beat(input logic [31:0] seed);
		awaddr  = AXIL_ADDR_W'($urandom() ^ seed);
		wdata   = $urandom() ^ seed;
		wstrb   = AXIL_STRB_W'($urandom());
		awvalid = 1'b1;
		awready = 1'b1;
		wvalid  = 1'b1;
		wready  = 1'b1;
		@(negedge clk);
		awvalid = 1'b0;
		awready = 1'b0;
		wvalid  = 1'b0;
		wready  = 1'b0;
	endtask

	task automatic b_beat();
		bresp  = 2'b00;
		bvalid = 1'b1;
		bready = 1'b1;
		@(negedge clk);
		bvalid = 1'b0;
		bready = 1'b0;
	endtask

	task automatic read_beat(input logic [31:0] seed);
		araddr  = AXIL_ADDR_W'($urandom() ^ seed);
		arvalid = 1'b1;
		arready = 1'b1;
		@(negedge clk);
		arvalid = 1'b0;
		arready = 1'b0;
	endtask

	task automatic r_beat(input logic [31:0] seed);
		rdata  = $urandom() ^ seed;
		rresp  = 2'b00;
		rvalid = 1'b1;
		rready = 1'b1;
		@(negedge clk);
		rvalid = 1'b0;
		rready = 1'b0;
	endtask

	////////////////////
	// Scenarios
	////////////////////

	// Three writes and two reads each answered two cycles later
	task automatic run_clean(input logic [31:0] seed);
		repeat (3)
		begin
			write_beat(seed);
			repeat (2) @(negedge clk);
			b_beat();
		end
		repeat (2)
		begin
			read_beat(seed);
			repeat (2) @(negedge clk);
			r_beat(seed);
		end
	endtask

	// Two reads left open and checked well before the timer limit
	task automatic run_rd_pending(input logic [31:0] seed);
		read_beat(seed);
		read_beat(seed);
		compare("o_rd_outstanding", rd_cnt, 2);
		compare("o_fault", fault, 0);
		read_beat(seed);
		r_beat(seed);
		r_beat(seed);
	endtask

	// W stalled one cycle while its data moves before it is taken
	task automatic run_w_unstable(input logic [31:0] seed);
		awaddr  = AXIL_ADDR_W'($urandom() ^ seed);
		wdata   = $urandom() ^ seed;
		wstrb   = '1;
		awvalid = 1'b1;
		awready = 1'b1;
		wvalid  = 1'b1;
		@(negedge clk);
		awvalid = 1'b0;
		awready = 1'b0;
		wdata   = ~wdata;
		wready  = 1'b1;
		@(negedge clk);
		wvalid = 1'b0;
		wready = 1'b0;
		b_beat();
	endtask

	// R with no read behind it and held stalled past the limit
	task automatic run_r_orphan(input logic [31:0] seed);
		rdata  = $urandom() ^ seed;
		rresp  = 2'b00;
		rvalid = 1'b1;
		repeat (LIMIT + 2) @(negedge clk);
		// Closing AR and R fire together so the count stays at zero
		araddr  = AXIL_ADDR_W'($urandom() ^ seed);
		arvalid = 1'b1;
		arready = 1'b1;
		rready  = 1'b1;
		@(negedge clk);
		bus_idle();
	endtask

	// B withheld past the response limit
	task automatic run_wr_timeout(input logic [31:0] seed);
		write_beat(seed);
		repeat (LIMIT + 2) @(negedge clk);
		b_beat();
	endtask

	// B stalled by bready with AW waiting behind it
	task automatic run_b_stall(input logic [31:0] seed);
		write_beat(seed);
		bresp   = 2'b00;
		bvalid  = 1'b1;
		awvalid = 1'b1;
		repeat (LIMIT + 2) @(negedge clk);
		// AW and B both fire here so one address beat stays open
		awready = 1'b1;
		bready  = 1'b1;
		@(negedge clk);
		bus_idle();
	endtask

	// Fault raised and then cleared by reset
	task automatic run_reset_clear(input logic [31:0] seed);
		read_beat(seed);
		bresp  = 2'b00;
		bvalid = 1'b1;
		repeat (2) @(negedge clk);
		compare("o_fault", fault, 1);
		compare("o_rd_outstanding", rd_cnt, 1);
		apply_reset();
	endtask

	task automatic run_scenario(input row_t row);
		case (row.code)
			SC_CLEAN:      run_clean(row.seed);
			SC_RD_PENDING: run_rd_pending(row.seed);
			SC_W_UNSTABLE: run_w_unstable(row.seed);
			SC_R_ORPHAN:   run_r_orphan(row.seed);
			SC_WR_TIMEOUT: run_wr_timeout(row.seed);
			SC_B_STALL:    run_b_stall(row.seed);
			SC_RESET_CLR:  run_reset_clear(row.seed);
			default:
			begin
				$display("Row %0d holds an unknown scenario code %0d", row_idx, row.code);
				$display("Test failures found");
				$fatal(1, "bad scenario table");
			end
		endcase
	endtask

	task automatic check_outputs(input row_t row);
		compare("o_fault_flags", fault_flags, row.exp_flags);
		compare("o_first_fault", first_fault, row.exp_first);
		compare("o_fault", fault, row.exp_flags != '0);
		compare("o_awr_outstanding", awr_cnt, row.exp_awr);
		compare("o_wr_outstanding", wr_cnt, row.exp_wr);
		compare("o_rd_outstanding", rd_cnt, row.exp_rd);
	endtask

	function automatic row_t make_row(input logic [3:0] code, input logic [15:0] flags,
			input int first, input int awr, input int wr, input int rd);
		row_t row;
		row.code      = code;
		row.seed      = $urandom();
		row.exp_flags = flags;
		row.exp_first = 4'(first);
		row.exp_awr   = LGDEPTH'(awr);
		row.exp_wr    = LGDEPTH'(wr);
		row.exp_rd    = LGDEPTH'(rd);
		return row;
	endfunction

	////////////////////
	// Main sequence
	////////////////////

	initial
	begin
		rst_req = 1'b0;
		bus_idle();
		awaddr      = '0;
		araddr      = '0;
		wdata       = '0;
		rdata       = '0;
		wstrb       = '0;
		bresp       = '0;
		rresp       = '0;
		row_idx     = 0;
		void'($urandom(32'h468));
		// Code, flags, first index, AW count, W count, read count
		rows[0] = make_row(SC_CLEAN, 16'h0, 0, 0, 0, 0);
		rows[1] = make_row(SC_RD_PENDING, 16'h0, 0, 0, 0, 1);
		rows[2] = make_row(SC_W_UNSTABLE, 16'(1) << FB_W_UNSTABLE, FB_W_UNSTABLE, 0, 0, 0);
		rows[3] = make_row(SC_R_ORPHAN, (16'(1) << FB_R_ORPHAN) | (16'(1) << FB_R_STALL),
			FB_R_ORPHAN, 0, 0, 0);
		rows[4] = make_row(SC_WR_TIMEOUT, 16'(1) << FB_WR_TIMEOUT, FB_WR_TIMEOUT, 0, 0, 0);
		rows[5] = make_row(SC_B_STALL, 16'(1) << FB_B_STALL, FB_B_STALL, 1, 0, 0);
		rows[6] = make_row(SC_RESET_CLR, 16'h0, 0, 0, 0, 0);
		wait (rst_n === 1'b1);
		@(negedge clk);
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			row_idx = i;
			apply_reset();
			run_scenario(rows[i]);
			repeat (3) @(negedge clk);
			check_outputs(rows[i]);
		end
		if (assert_fails == 0)
		begin
			$display("All tests passed!");
		end
		else
		begin
			$display("Test failures found");
		end
		$finish;
	end

	// Stop at the first assertion failure
	always @(negedge clk)
	begin
		if (assert_fails != 0)
		begin
			$display("A fault collector assertion failed before %0t ns", $time);
			$display("Test failures found");
			$fatal(1, "assertion failure");
		end
	end

	// Watchdog sized from the table length
	initial
	begin
		#(NUM_ROWS * ROW_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run hung",
			NUM_ROWS * ROW_CYCLES);
		$display("Test failures found");
		$fatal(1, "timeout");
	end

endmodule

// File: all.f
hdl/axil_mon_pkg.sv
hdl/axil_chan_watch.sv
hdl/axil_wr_tracker.sv
hdl/axil_rd_tracker.sv
hdl/axil_fault_collect.sv
hdl/axil_monitor_top.sv
tests/tb_clk_gen.sv
tests/axil_monitor_assertions.sv
tests/tb_axil_monitor.sv
